//--- design/usb_hid_defines.svh
`ifndef USB_HID_DEFINES_SVH
`define USB_HID_DEFINES_SVH

// low-speed line timing at 12 MHz, 1.5 Mbit/s
`define USB_BIT_CLKS      8   // clocks per bit
`define USB_SAMPLE_PHASE  4   // mid-bit phase for the line sample

// NRZI receive
`define USB_STUFF_LIMIT   6   // ones in a row before a stuffed zero

// packet framing
`define USB_HDR_BYTES     2   // sync + pid, never passed up
`define USB_MAX_PAYLOAD   8   // report window in bytes, rest dropped

`endif

//--- design/usb_hid_pkg.sv
package usb_hid_pkg;

    // device class as chosen by whoever enumerated the device
    typedef enum logic [1:0] {
        HID_NONE     = 2'd0,
        HID_KEYBOARD = 2'd1,
        HID_MOUSE    = 2'd2,
        HID_GAMEPAD  = 2'd3
    } hid_typ_e;

    // one mid-bit sample of the bus
    typedef struct packed {
        logic dp;
        logic dm;
    } line_sym_t;

    // payload byte, index counted after sync and pid
    typedef struct packed {
        logic [7:0] data;
        logic [2:0] index;
    } rx_byte_t;

    // boot keyboard report
    typedef struct packed {
        logic [7:0] modifiers;  // ctrl/shift/alt/gui, left and right
        logic [7:0] key1;
        logic [7:0] key2;
        logic [7:0] key3;
        logic [7:0] key4;
    } key_report_t;

    // boot mouse report
    typedef struct packed {
        logic [7:0]        btn;  // bit 0 left, bit 1 right, bit 2 middle
        logic signed [7:0] dx;   // zeroed after every report pulse
        logic signed [7:0] dy;
    } mouse_report_t;

    // generic gamepad, directions plus six buttons
    typedef struct packed {
        logic l;
        logic r;
        logic u;
        logic d;
        logic a;
        logic b;
        logic x;
        logic y;
        logic sel;
        logic sta;
    } game_report_t;

endpackage

//--- design/usb_line_sampler.sv
`timescale 1ns/1ns
`include "usb_hid_defines.svh"

module usb_line_sampler (
    input  logic                  usbclk,
    input  logic                  usbrst_n,
    input  logic                  usb_dp,
    input  logic                  usb_dm,
    output usb_hid_pkg::line_sym_t sym,
    output logic                  sym_stb,
    output logic                  idle
);

    localparam int PH_W = $clog2(`USB_BIT_CLKS);

    logic [1:0]      dp_sync;  // [0] may go metastable and [1] is safe
    logic [1:0]      dm_sync;
    logic            dm_prev;  // last synchronised dm for edge detect
    logic [PH_W-1:0] phase;    // position inside the current bit

    logic dp_s;
    logic dm_s;
    logic k_state;
    logic se0;
    logic dm_edge;
    logic at_sample;

    assign dp_s      = dp_sync[1];
    assign dm_s      = dm_sync[1];
    assign k_state   = dp_s & ~dm_s;  // low-speed K
    assign se0       = ~dp_s & ~dm_s;
    assign dm_edge   = dm_s != dm_prev;
    assign at_sample = phase == PH_W'(`USB_SAMPLE_PHASE);

    always_ff @(posedge usbclk) begin
        if (!usbrst_n) begin
            dp_sync <= 2'b00;  // bus parks in J
            dm_sync <= 2'b11;
            dm_prev <= 1'b1;
            phase   <= '0;
            sym_stb <= 1'b0;
            idle    <= 1'b1;
        end else begin
            dp_sync <= {dp_sync[0], usb_dp};
            dm_sync <= {dm_sync[0], usb_dm};
            dm_prev <= dm_s;

            // between packets the phase waits for the first K
            if (idle && !k_state) begin
                phase <= '0;
            end else if (dm_edge) begin
                phase <= PH_W'(1);  // realign on every transition
            end else if (phase == PH_W'(`USB_BIT_CLKS - 1)) begin
                phase <= '0;
            end else begin
                phase <= phase + 1'b1;
            end

            sym_stb <= at_sample;  // once per bit

            if (at_sample && se0) begin
                idle <= 1'b1;  // eop seen and its se0 strobe still goes out
            end else if (idle && k_state) begin
                idle <= 1'b0;  // start of sync
            end
        end
    end

    // mid-bit line state handed to the decoder
    always_ff @(posedge usbclk) begin
        if (at_sample) begin
            sym.dp <= dp_s;
            sym.dm <= dm_s;
        end
    end

    // phase realignment must never produce back to back samples
    a_one_sample_per_bit: assert property (
        @(posedge usbclk) disable iff (!usbrst_n) sym_stb |=> !sym_stb
    );

endmodule

//--- design/nrzi_decoder.sv
`timescale 1ns/1ns
`include "usb_hid_defines.svh"

module nrzi_decoder (
    input  logic                   usbclk,
    input  logic                   usbrst_n,
    input  usb_hid_pkg::line_sym_t sym,
    input  logic                   sym_stb,
    output logic                   bit_val,
    output logic                   bit_stb,
    output logic                   sop_stb,
    output logic                   eop_stb
);

    localparam int ONES_W = $clog2(`USB_STUFF_LIMIT + 1);

    logic              in_pkt;   // between first K and se0
    logic              dm_prev;  // dm of the previous sample
    logic [ONES_W-1:0] ones;     // current run of ones

    logic se0;
    logic k_state;
    logic nrzi_bit;
    logic stuffed;

    assign se0      = ~sym.dp & ~sym.dm;
    assign k_state  = sym.dp & ~sym.dm;
    assign nrzi_bit = sym.dm == dm_prev;  // no transition means one
    assign stuffed  = ones == ONES_W'(`USB_STUFF_LIMIT);

    always_ff @(posedge usbclk) begin
        if (!usbrst_n) begin
            in_pkt  <= 1'b0;
            dm_prev <= 1'b1;  // J
            ones    <= '0;
            bit_val <= 1'b0;
            bit_stb <= 1'b0;
            sop_stb <= 1'b0;
            eop_stb <= 1'b0;
        end else begin
            bit_stb <= 1'b0;  // all strobes one cycle
            sop_stb <= 1'b0;
            eop_stb <= 1'b0;
            if (sym_stb) begin
                if (se0) begin
                    eop_stb <= in_pkt;  // once per packet
                    in_pkt  <= 1'b0;
                    dm_prev <= 1'b1;    // bus returns to J after se0
                    ones    <= '0;
                end else if (in_pkt || k_state) begin
                    // first K is also bit 0 of sync
                    if (!in_pkt) begin
                        in_pkt  <= 1'b1;
                        sop_stb <= 1'b1;
                    end
                    dm_prev <= sym.dm;
                    if (stuffed) begin
                        ones <= '0;  // stuffed zero, swallowed
                    end else begin
                        bit_stb <= 1'b1;
                        bit_val <= nrzi_bit;
                        ones    <= nrzi_bit ? ones + 1'b1 : '0;
                    end
                end
            end
        end
    end

    // se0 closes the packet without ever decoding as data
    a_bit_not_eop: assert property (
        @(posedge usbclk) disable iff (!usbrst_n) !(bit_stb && eop_stb)
    );

endmodule

//--- design/byte_assembler.sv
`timescale 1ns/1ns
`include "usb_hid_defines.svh"

module byte_assembler (
    input  logic                  usbclk,
    input  logic                  usbrst_n,
    input  logic                  bit_val,
    input  logic                  bit_stb,
    input  logic                  sop_stb,
    input  logic                  eop_stb,
    output usb_hid_pkg::rx_byte_t pay,
    output logic                  pay_stb,
    output logic                  frame_end_stb
);

    localparam int LAST_BYTE = `USB_HDR_BYTES + `USB_MAX_PAYLOAD;
    localparam int BYTE_W    = $clog2(LAST_BYTE + 1);

    logic [2:0]        bit_cnt;   // bit within byte
    logic [BYTE_W-1:0] byte_cnt;  // saturating count of whole bytes since sop
    logic [7:0]        shreg;     // lsb arrives first
    logic              sent;      // some payload went out this frame

    logic [2:0]        bit_idx;
    logic [BYTE_W-1:0] byte_idx;
    logic [7:0]        byte_nxt;
    logic              in_window;
    logic              byte_done;

    // sop comes with the first bit, so counts restart right here
    assign bit_idx   = sop_stb ? 3'd0 : bit_cnt;
    assign byte_idx  = sop_stb ? '0 : byte_cnt;
    assign byte_nxt  = {bit_val, shreg[7:1]};
    assign byte_done = bit_stb && (bit_idx == 3'd7);
    assign in_window = (byte_idx >= BYTE_W'(`USB_HDR_BYTES)) &&
                       (byte_idx < BYTE_W'(LAST_BYTE));

    always_ff @(posedge usbclk) begin
        if (!usbrst_n) begin
            bit_cnt       <= 3'd0;
            byte_cnt      <= '0;
            sent          <= 1'b0;
            pay_stb       <= 1'b0;
            frame_end_stb <= 1'b0;
        end else begin
            pay_stb       <= 1'b0;
            frame_end_stb <= eop_stb && sent;  // header-only frames stay silent
            if (eop_stb) begin
                bit_cnt  <= 3'd0;
                byte_cnt <= '0;
                sent     <= 1'b0;
            end else begin
                if (sop_stb) begin
                    sent <= 1'b0;
                end
                if (bit_stb) begin
                    bit_cnt <= bit_idx + 3'd1;  // wraps to 0 after bit 7
                end
                if (byte_done) begin
                    if (byte_idx != BYTE_W'(LAST_BYTE)) begin
                        byte_cnt <= byte_idx + 1'b1;
                    end
                    if (in_window) begin
                        pay_stb <= 1'b1;
                        sent    <= 1'b1;
                    end
                end
            end
        end
    end

    // shifter and output byte
    always_ff @(posedge usbclk) begin
        if (bit_stb) begin
            shreg <= byte_nxt;
        end
        if (byte_done) begin
            pay.data  <= byte_nxt;
            pay.index <= 3'(byte_idx - BYTE_W'(`USB_HDR_BYTES));
        end
    end

    // index 0 only for the first payload byte of a frame, so it never wraps past 7
    a_index_in_range: assert property (
        @(posedge usbclk) disable iff (!usbrst_n)
            pay_stb |-> ((pay.index == 3'd0) == !$past(sent))
    );

endmodule

//--- design/hid_report_decoder.sv
`timescale 1ns/1ns
`include "usb_hid_defines.svh"

module hid_report_decoder (
    input  logic                            usbclk,
    input  logic                            usbrst_n,
    input  usb_hid_pkg::hid_typ_e           dev_typ,
    input  usb_hid_pkg::rx_byte_t           pay,
    input  logic                            pay_stb,
    input  logic                            frame_end_stb,
    output logic                            report,
    output usb_hid_pkg::key_report_t        key,
    output usb_hid_pkg::mouse_report_t      mouse,
    output usb_hid_pkg::game_report_t       game,
    output logic [`USB_MAX_PAYLOAD*8-1:0]   raw_report
);

    logic valid;  // gamepad record usable, from byte 0

    always_ff @(posedge usbclk) begin
        if (!usbrst_n) begin
            report     <= 1'b0;
            valid      <= 1'b0;
            key        <= '0;
            mouse      <= '0;
            game       <= '0;
            raw_report <= '0;
        end else begin
            // frame_end only fires after at least one payload byte
            report <= frame_end_stb && (dev_typ != usb_hid_pkg::HID_NONE);

            if (report) begin
                mouse.dx <= '0;  // motion is relative, consumed by the pulse
                mouse.dy <= '0;
            end

            if (pay_stb) begin
                raw_report[{pay.index, 3'b000} +: 8] <= pay.data;

                case (dev_typ)
                    usb_hid_pkg::HID_KEYBOARD: begin
                        case (pay.index)
                            3'd0: key.modifiers <= pay.data;
                            3'd2: key.key1 <= pay.data;  // byte 1 is reserved
                            3'd3: key.key2 <= pay.data;
                            3'd4: key.key3 <= pay.data;
                            3'd5: key.key4 <= pay.data;
                            default: ;
                        endcase
                    end
                    usb_hid_pkg::HID_MOUSE: begin
                        case (pay.index)
                            3'd0: mouse.btn <= pay.data;
                            3'd1: mouse.dx <= pay.data;
                            3'd2: mouse.dy <= pay.data;
                            default: ;
                        endcase
                    end
                    usb_hid_pkg::HID_GAMEPAD: begin
                        case (pay.index)
                            3'd0: begin
                                // low bits 10 flag a DualShock2 adapter side record
                                if (pay.data[1:0] != 2'b10) begin
                                    valid  <= 1'b1;
                                    game.l <= 1'b0;
                                    game.r <= 1'b0;
                                    game.u <= 1'b0;
                                    game.d <= 1'b0;
                                end else begin
                                    valid <= 1'b0;
                                end
                                // some pads put the x axis here
                                if (pay.data == 8'h00) {game.l, game.r} <= 2'b10;
                                if (pay.data == 8'hff) {game.l, game.r} <= 2'b01;
                            end
                            3'd1: begin
                                if (pay.data == 8'h00) {game.u, game.d} <= 2'b10;
                                if (pay.data == 8'hff) {game.u, game.d} <= 2'b01;
                            end
                            3'd3: if (valid) begin  // x axis, centre leaves both clear
                                if (pay.data[7:6] == 2'b00) {game.l, game.r} <= 2'b10;
                                if (pay.data[7:6] == 2'b11) {game.l, game.r} <= 2'b01;
                            end
                            3'd4: if (valid) begin  // y axis
                                if (pay.data[7:6] == 2'b00) {game.u, game.d} <= 2'b10;
                                if (pay.data[7:6] == 2'b11) {game.u, game.d} <= 2'b01;
                            end
                            3'd5: if (valid) begin
                                game.x <= pay.data[4];
                                game.a <= pay.data[5];
                                game.b <= pay.data[6];
                                game.y <= pay.data[7];
                            end
                            3'd6: if (valid) begin
                                game.sel <= pay.data[4];
                                game.sta <= pay.data[5];
                            end
                            default: ;
                        endcase
                    end
                    default: ;  // no device, raw bytes only
                endcase
            end
        end
    end

endmodule

//--- design/usb_hid_rx.sv
`timescale 1ns/1ns
`include "usb_hid_defines.svh"

module usb_hid_rx (
    input  logic                          usbclk,
    input  logic                          usbrst_n,
    input  logic                          usb_dp,
    input  logic                          usb_dm,
    input  usb_hid_pkg::hid_typ_e         dev_typ,
    output logic                          report,
    output usb_hid_pkg::key_report_t      key,
    output usb_hid_pkg::mouse_report_t    mouse,
    output usb_hid_pkg::game_report_t     game,
    output logic [`USB_MAX_PAYLOAD*8-1:0] raw_report
);

    usb_hid_pkg::line_sym_t sym;
    usb_hid_pkg::rx_byte_t  pay;
    logic sym_stb;
    logic idle;
    logic bit_val;
    logic bit_stb;
    logic sop_stb;
    logic eop_stb;
    logic pay_stb;
    logic frame_end_stb;

    usb_line_sampler i_line_sampler (
        .usbclk   (usbclk),
        .usbrst_n (usbrst_n),
        .usb_dp   (usb_dp),
        .usb_dm   (usb_dm),
        .sym      (sym),
        .sym_stb  (sym_stb),
        .idle     (idle)
    );

    nrzi_decoder i_nrzi_decoder (
        .usbclk   (usbclk),
        .usbrst_n (usbrst_n),
        .sym      (sym),
        .sym_stb  (sym_stb),
        .bit_val  (bit_val),
        .bit_stb  (bit_stb),
        .sop_stb  (sop_stb),
        .eop_stb  (eop_stb)
    );

    byte_assembler i_byte_assembler (
        .usbclk        (usbclk),
        .usbrst_n      (usbrst_n),
        .bit_val       (bit_val),
        .bit_stb       (bit_stb),
        .sop_stb       (sop_stb),
        .eop_stb       (eop_stb),
        .pay           (pay),
        .pay_stb       (pay_stb),
        .frame_end_stb (frame_end_stb)
    );

    hid_report_decoder i_report_decoder (
        .usbclk        (usbclk),
        .usbrst_n      (usbrst_n),
        .dev_typ       (dev_typ),
        .pay           (pay),
        .pay_stb       (pay_stb),
        .frame_end_stb (frame_end_stb),
        .report        (report),
        .key           (key),
        .mouse         (mouse),
        .game          (game),
        .raw_report    (raw_report)
    );

    // sampler line state and decoder packet state must agree
    a_sop_leaves_idle: assert property (
        @(posedge usbclk) disable iff (!usbrst_n) sop_stb |-> !idle
    );
    a_eop_enters_idle: assert property (
        @(posedge usbclk) disable iff (!usbrst_n) eop_stb |-> idle
    );

endmodule

//--- testbench/hid_checker.sv
`timescale 1ns/1ns
`include "usb_hid_defines.svh"

module hid_checker (
    input  logic                          usbclk,
    input  logic                          usbrst_n,
    input  logic                          report,
    input  usb_hid_pkg::key_report_t      key,
    input  usb_hid_pkg::mouse_report_t    mouse,
    input  usb_hid_pkg::game_report_t     game,
    input  logic [`USB_MAX_PAYLOAD*8-1:0] raw_report,
    output int                            tests_run,
    output int                            tests_failed
);

    localparam int REPORT_TIMEOUT = 400;  // cycles
    localparam int RAW_W          = `USB_MAX_PAYLOAD * 8;

    int                         report_cnt;   // pulses seen since reset
    int                         checked_cnt;  // pulses already consumed by a test
    logic                       report_q;
    usb_hid_pkg::key_report_t   cap_key;      // outputs frozen at the pulse
    usb_hid_pkg::mouse_report_t cap_mouse;
    usb_hid_pkg::game_report_t  cap_game;
    logic [RAW_W-1:0]           cap_raw;
    usb_hid_pkg::mouse_report_t post_mouse;   // one cycle after the pulse

    initial begin
        tests_run    = 0;
        tests_failed = 0;
        checked_cnt  = 0;
    end

    always @(posedge usbclk) begin
        if (!usbrst_n) begin
            report_cnt <= 0;
            report_q   <= 1'b0;
        end else begin
            report_q <= report;
            if (report) begin
                report_cnt <= report_cnt + 1;
                cap_key    <= key;
                cap_mouse  <= mouse;
                cap_game   <= game;
                cap_raw    <= raw_report;
            end
            if (report_q) begin
                post_mouse <= mouse;  // dx, dy should be cleared by now
            end
        end
    end

    // called once per packet, right after the line is back in J
    task automatic expect_report(
        input string                      name,
        input logic                       want,
        input usb_hid_pkg::key_report_t   exp_key,
        input usb_hid_pkg::mouse_report_t exp_mouse,
        input usb_hid_pkg::game_report_t  exp_game,
        input logic [RAW_W-1:0]           exp_raw
    );
        int   waited;
        logic seen;
        logic bad;
        waited = 0;
        bad    = 1'b0;
        while (report_cnt == checked_cnt && waited < REPORT_TIMEOUT) begin
            @(negedge usbclk);  // counters settle on posedge
            waited++;
        end
        seen = report_cnt != checked_cnt;
        repeat (2) @(negedge usbclk);  // post capture lands
        if (!want) begin
            if (seen) begin
                $display("test %s: report pulse arrived with no device type set", name);
                bad = 1'b1;
            end else begin
                $display("test %s: no report pulse in %0d cycles, as expected",
                         name, REPORT_TIMEOUT);
            end
        end else if (!seen) begin
            $display("test %s: no report pulse within %0d cycles", name, REPORT_TIMEOUT);
            bad = 1'b1;
        end else if (cap_key != exp_key) begin
            $display("Error: test %s key expected %h actual %h", name, exp_key, cap_key);
            bad = 1'b1;
        end else if (cap_mouse != exp_mouse) begin
            $display("Error: test %s mouse expected %h actual %h", name, exp_mouse, cap_mouse);
            bad = 1'b1;
        end else if (cap_game != exp_game) begin
            $display("Error: test %s game expected %h actual %h", name, exp_game, cap_game);
            bad = 1'b1;
        end else if (cap_raw != exp_raw) begin
            $display("Error: test %s raw_report expected %h actual %h", name, exp_raw, cap_raw);
            bad = 1'b1;
        end else if (post_mouse.dx != 8'sd0 || post_mouse.dy != 8'sd0) begin
            $display("Error: test %s dx/dy after report expected 0000 actual %h%h",
                     name, post_mouse.dx, post_mouse.dy);
            bad = 1'b1;
        end else begin
            $display("test %s: ok", name);
        end
        checked_cnt = report_cnt;
        tests_run++;
        if (bad) begin
            tests_failed++;
        end
    endtask

endmodule

//--- testbench/tb_usb_hid_rx.sv
`timescale 1ns/1ns
`include "usb_hid_defines.svh"

module tb_usb_hid_rx;

    localparam int MAX_GAP = 5;  // extra idle clocks between packets
    localparam int RAW_W   = `USB_MAX_PAYLOAD * 8;

    logic                       usbclk;
    logic                       usbrst_n;
    logic                       usb_dp;
    logic                       usb_dm;
    usb_hid_pkg::hid_typ_e      dev_typ;
    logic                       report;
    usb_hid_pkg::key_report_t   key;
    usb_hid_pkg::mouse_report_t mouse;
    usb_hid_pkg::game_report_t  game;
    logic [RAW_W-1:0]           raw_report;
    int                         tests_run;
    int                         tests_failed;

    logic bus_j;     // nrzi level on the wire where 1 is J
    int   ones_run;  // ones since last transition

    // vector file fields
    int               fd;
    int               fields;
    int               parse_err;
    int               typ_i;
    int               nbytes;
    string            line;
    string            name;
    logic [7:0]       pay_b [8];
    logic [39:0]      exp_key;
    logic [23:0]      exp_mouse;
    logic [9:0]       exp_game;
    logic [RAW_W-1:0] exp_raw;

    usb_hid_rx i_usb_hid_rx (
        .usbclk     (usbclk),
        .usbrst_n   (usbrst_n),
        .usb_dp     (usb_dp),
        .usb_dm     (usb_dm),
        .dev_typ    (dev_typ),
        .report     (report),
        .key        (key),
        .mouse      (mouse),
        .game       (game),
        .raw_report (raw_report)
    );

    hid_checker i_checker (
        .usbclk       (usbclk),
        .usbrst_n     (usbrst_n),
        .report       (report),
        .key          (key),
        .mouse        (mouse),
        .game         (game),
        .raw_report   (raw_report),
        .tests_run    (tests_run),
        .tests_failed (tests_failed)
    );

    always #2 usbclk = ~usbclk;  // 4 ns

    // entered and left on a falling edge
    task automatic put_symbol(input logic dp, input logic dm);
        usb_dp = dp;
        usb_dm = dm;
        repeat (`USB_BIT_CLKS) @(negedge usbclk);
    endtask

    task automatic transmit_bit(input logic b);
        if (!b) begin
            bus_j = ~bus_j;  // zero is a transition
        end
        put_symbol(~bus_j, bus_j);
        ones_run = b ? ones_run + 1 : 0;
        if (ones_run == `USB_STUFF_LIMIT) begin
            bus_j = ~bus_j;  // stuffed zero
            put_symbol(~bus_j, bus_j);
            ones_run = 0;
        end
    endtask

    task automatic shift_out_byte(input logic [7:0] v);
        int i;
        for (i = 0; i < 8; i++) begin
            transmit_bit(v[i]);  // lsb first
        end
    endtask

    task automatic send_packet(input usb_hid_pkg::hid_typ_e typ, input int n,
                               input logic [RAW_W-1:0] payload);
        int i;
        dev_typ  = typ;
        bus_j    = 1'b1;
        ones_run = 0;
        shift_out_byte(8'h80);  // sync
        shift_out_byte(8'hc3);  // pid
        for (i = 0; i < n && i < `USB_MAX_PAYLOAD; i++) begin
            shift_out_byte(payload[8*i +: 8]);
        end
        put_symbol(1'b0, 1'b0);  // eop as two bits of se0
        put_symbol(1'b0, 1'b0);
        put_symbol(1'b0, 1'b1);  // back to J
    endtask

    initial begin
        usbclk    = 1'b0;
        usbrst_n  = 1'b0;
        usb_dp    = 1'b0;  // J
        usb_dm    = 1'b1;
        dev_typ   = usb_hid_pkg::HID_NONE;
        bus_j     = 1'b1;
        ones_run  = 0;
        parse_err = 0;
        void'($urandom(32'hacc7));
        repeat (3) @(negedge usbclk);
        usbrst_n = 1'b1;
        repeat (4) @(negedge usbclk);

        fd = $fopen("testbench/hid_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open testbench/hid_vectors.txt");
            $display("Simulation finished: FAIL");
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line[0] != "#") begin  // skip blank and comment lines
                    fields = $sscanf(line, "%s %d %d %h %h %h %h %h %h %h %h %h %h %h %h",
                                     name, typ_i, nbytes, pay_b[0], pay_b[1], pay_b[2],
                                     pay_b[3], pay_b[4], pay_b[5], pay_b[6], pay_b[7],
                                     exp_key, exp_mouse, exp_game, exp_raw);
                    if (fields != 15) begin
                        $display("vector line could not be parsed: %s", line);
                        parse_err++;
                    end else begin
                        send_packet(usb_hid_pkg::hid_typ_e'(typ_i[1:0]), nbytes,
                                    {pay_b[7], pay_b[6], pay_b[5], pay_b[4],
                                     pay_b[3], pay_b[2], pay_b[1], pay_b[0]});
                        // a pulse is due only for a known device type
                        i_checker.expect_report(name, typ_i != 0, exp_key, exp_mouse,
                                                exp_game, exp_raw);
                        repeat ($urandom % (MAX_GAP + 1)) @(negedge usbclk);
                    end
                end
            end
            $fclose(fd);
            $display("%0d tests run, %0d failed, %0d bad vector lines",
                     tests_run, tests_failed, parse_err);
            if (tests_failed == 0 && parse_err == 0 && tests_run > 0) begin
                $display("Simulation finished: PASS");
            end else begin
                $display("Simulation finished: FAIL");
            end
        end
        $finish;
    end

endmodule

//--- testbench/hid_vectors.txt
# name typ(0 none,1 kbd,2 mouse,3 pad) nbytes b0..b7 (hex, lsb byte first)
# then expected key{mod,k1..k4} mouse{btn,dx,dy} game{l..sta} raw{b7..b0}, all hex
kbd_basic       1 8 02 00 04 05 06 07 00 00 0204050607 000000 000 0000070605040002
mouse_move      2 4 01 05 fb 00 00 00 00 00 0204050607 0105fb 000 0000070600fb0501
kbd_ff_stuff    1 8 ff ff 1e 1f 20 21 ff 00 ff1e1f2021 010000 000 00ff21201f1effff
pad_axes        3 8 01 80 00 10 f0 a0 30 00 ff1e1f2021 010000 267 0030a0f010008001
pad_ds2_skip    3 8 02 80 00 f0 00 50 00 00 ff1e1f2021 010000 267 00005000f0008002
pad_byte0_ff    3 8 ff 00 00 80 40 50 20 00 ff1e1f2021 010000 199 00205040800000ff
mouse_neg       2 3 04 ff 80 00 00 00 00 00 ff1e1f2021 04ff80 199 002050408080ff04
none_silent     0 4 11 22 33 44 00 00 00 00 0000000000 000000 000 0000000000000000
kbd_after_none  1 8 01 00 2c 00 00 00 00 00 012c000000 040000 199 00000000002c0001

//--- build.f
+incdir+design
design/usb_hid_pkg.sv
design/usb_line_sampler.sv
design/nrzi_decoder.sv
design/byte_assembler.sv
design/hid_report_decoder.sv
design/usb_hid_rx.sv
testbench/hid_checker.sv
testbench/tb_usb_hid_rx.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build with verilator, run, and decide on the pass line in sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert -j 0 -f build.f --top-module tb_usb_hid_rx -o tb_sim \
    > sim.log 2>&1 \
    && ./obj_dir/tb_sim >> sim.log 2>&1
cat sim.log
grep -q "Simulation finished: PASS" sim.log && exit 0 || exit 1
